/* cache.f */
hdl/cache_geom_pkg.sv
hdl/cache_types.sv
hdl/cache_array.sv
hdl/plru.sv
hdl/pipe_one.sv
hdl/pipe_two.sv
hdl/miss_ctrl.sv
hdl/cache.sv
tests/mem_model.sv
tests/cache_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f cache.f --top-module cache_tb -o cache_sim || exit 1
./obj_dir/cache_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" && exit 0 || exit 1

/* tests/cache_tb.sv */
module cache_tb;

    localparam int          mem_latency = 4;
    localparam logic [31:0] fill_key    = 32'hA5C3_1F00;

    typedef struct {
        int          test;
        logic [31:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
        logic [31:0] rdata;
        int          kind;      // 0 any, 1 hit in one cycle, 2 fill, 3 fill after write-back.
        logic [31:0] wb_addr;
    } step_t;

    logic               clk;
    logic               rst_n;
    logic [31:0]        ufp_addr;
    logic [3:0]         ufp_rmask;
    logic [3:0]         ufp_wmask;
    logic [31:0]        ufp_wdata;
    logic [31:0]        ufp_rdata;
    logic               ufp_resp;
    logic [31:0]        dfp_addr;
    logic               dfp_read;
    logic               dfp_write;
    cache_types::line_t dfp_wdata;
    cache_types::line_t dfp_rdata;
    logic               dfp_resp;

    step_t       steps [$];
    logic [31:0] shadow [logic [31:0]];    // Built with the table.
    logic [31:0] live [logic [31:0]];      // Follows completed writes.
    string       names [1:6];
    int          seed = 57531;
    int          errors;
    int          checks;
    int          cycles;
    int          limit;
    int          rd_count;
    int          wb_count;
    logic [31:0] last_rd;
    logic [31:0] last_wb;

    cache UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_wdata (ufp_wdata),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_wdata (dfp_wdata),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    mem_model #(.latency(mem_latency), .fill_key(fill_key)) u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_wdata (dfp_wdata),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] mask);
        logic [31:0] w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                w[b * 8 +: 8] = data[b * 8 +: 8];
            end
        end
        return w;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : a ^ fill_key;
    endfunction

    function automatic logic [31:0] live_word(input logic [31:0] a);
        return live.exists(a) ? live[a] : a ^ fill_key;
    endfunction

    function automatic cache_types::line_t live_line(input logic [31:0] line_addr);
        cache_types::line_t l;
        for (int i = 0; i < 8; i++) begin
            l[i * 32 +: 32] = live_word(line_addr + 32'(i * 4));
        end
        return l;
    endfunction

    task automatic add_step(input int test, input logic [31:0] addr, input logic [3:0] rmask,
                            input logic [3:0] wmask, input logic [31:0] wdata, input int kind,
                            input logic [31:0] wb_addr);
        step_t s;
        s.test    = test;
        s.addr    = {addr[31:2], 2'b00};
        s.rmask   = rmask;
        s.wmask   = wmask;
        s.wdata   = wdata;
        s.rdata   = shadow_word(s.addr);
        s.kind    = kind;
        s.wb_addr = wb_addr;
        if (wmask != 4'h0) begin
            shadow[s.addr] = merge_word(s.rdata, wdata, wmask);
        end
        steps.push_back(s);
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] a;
        add_step(2, 32'h0000_1234, 4'hF, 4'h0, 32'h0, 2, 32'h0);
        add_step(2, 32'h0000_1234, 4'hF, 4'h0, 32'h0, 1, 32'h0);
        add_step(2, 32'h0000_1238, 4'hF, 4'h0, 32'h0, 1, 32'h0);
        add_step(3, 32'h0000_1238, 4'h0, 4'b0101, 32'h1122_3344, 1, 32'h0);
        add_step(3, 32'h0000_1238, 4'hF, 4'h0, 32'h0, 0, 32'h0);
        // Set 5 sees tags 0x100 to 0x104. Way 0 holds the dirty line and is the fifth victim.
        add_step(4, 32'h0002_00A4, 4'h0, 4'hF, 32'hDEAD_BEEF, 2, 32'h0);
        add_step(4, 32'h0002_02A0, 4'hF, 4'h0, 32'h0, 2, 32'h0);
        add_step(4, 32'h0002_04A0, 4'hF, 4'h0, 32'h0, 2, 32'h0);
        add_step(4, 32'h0002_06A0, 4'hF, 4'h0, 32'h0, 2, 32'h0);
        add_step(4, 32'h0002_08A0, 4'hF, 4'h0, 32'h0, 3, 32'h0002_00A0);
        add_step(4, 32'h0002_00A4, 4'hF, 4'h0, 32'h0, 2, 32'h0);
        add_step(6, 32'h0002_04A0, 4'hF, 4'h0, 32'h0, 1, 32'h0);
        add_step(6, 32'h0002_06A4, 4'hF, 4'h0, 32'h0, 1, 32'h0);
        add_step(6, 32'h0002_08A8, 4'hF, 4'h0, 32'h0, 1, 32'h0);
        add_step(6, 32'h0002_00A4, 4'hF, 4'h0, 32'h0, 1, 32'h0);
        // Eight lines of set 12 with eight words each, so ways get evicted often.
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            a = {23'h60 + 23'(r[2:0]), 4'd12, r[5:3], 2'b00};
            if (r[6]) begin
                add_step(5, a, 4'h0, (r[10:7] == 4'h0) ? 4'hF : r[10:7], $random(seed), 0, 0);
            end else begin
                add_step(5, a, 4'hF, 4'h0, 32'h0, 0, 32'h0);
            end
        end
    endtask

    // Every line that memory accepts must match the written data.
    always @(posedge clk) begin
        if (rst_n && dfp_resp) begin
            if (dfp_write) begin
                wb_count++;
                last_wb = dfp_addr;
                checks++;
                assert (dfp_wdata == live_line(dfp_addr)) else begin
                    $display("MISMATCH time=%0t dfp_wdata got %h expected %h",
                             $time, dfp_wdata, live_line(dfp_addr));
                    errors++;
                end
            end else if (dfp_read) begin
                rd_count++;
                last_rd = dfp_addr;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the cache gave no response within %0d cycles.", limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int          cyc;
        int          rd_before;
        int          wb_before;
        int          err_start;
        logic [31:0] line;
        clk       = 1'b0;
        rst_n     = 1'b0;
        ufp_addr  = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        rd_count  = 0;
        wb_count  = 0;
        names[1]  = "idle after reset";
        names[2]  = "read miss then hits";
        names[3]  = "partial write";
        names[4]  = "eviction order";
        names[5]  = "random mix";
        names[6]  = "back-to-back hits";
        build_table();
        limit = steps.size() * (2 * mem_latency + 4) + 16;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
            checks++;
            assert (!ufp_resp && !dfp_read && !dfp_write) else begin
                $display("Time %0t: the cache was active with no request.", $time);
                errors++;
            end
        end
        $display("test 1 %s: %0d errors", names[1], errors);
        err_start = errors;
        for (int i = 0; i < steps.size(); i++) begin
            ufp_addr  = steps[i].addr;
            ufp_rmask = steps[i].rmask;
            ufp_wmask = steps[i].wmask;
            ufp_wdata = steps[i].wdata;
            rd_before = rd_count;
            wb_before = wb_count;
            line      = {steps[i].addr[31:5], 5'b00000};
            cyc       = 0;
            do begin
                @(posedge clk);
                #1;
                cyc++;
            end while (!ufp_resp);
            if (steps[i].rmask != 4'h0) begin
                checks++;
                assert (ufp_rdata == steps[i].rdata) else begin
                    $display("MISMATCH time=%0t ufp_rdata got %h expected %h",
                             $time, ufp_rdata, steps[i].rdata);
                    errors++;
                end
            end else begin
                live[steps[i].addr] = merge_word(live_word(steps[i].addr), steps[i].wdata,
                                                 steps[i].wmask);
            end
            if (steps[i].kind == 1) begin
                checks++;
                assert (cyc == 1 && rd_count == rd_before) else begin
                    $display("Time %0t: hit at %h took %0d cycles or read memory.",
                             $time, steps[i].addr, cyc);
                    errors++;
                end
            end else if (steps[i].kind >= 2) begin
                checks++;
                assert (rd_count > rd_before) else begin
                    $display("Time %0t: the miss at %h fetched no line from memory.",
                             $time, steps[i].addr);
                    errors++;
                end
                if (rd_count > rd_before) begin
                    checks++;
                    assert (last_rd == line) else begin
                        $display("MISMATCH time=%0t dfp_addr got %h expected %h",
                                 $time, last_rd, line);
                        errors++;
                    end
                end
            end
            if (steps[i].kind == 3) begin
                checks++;
                assert (wb_count > wb_before) else begin
                    $display("Time %0t: the miss at %h wrote no dirty line back.",
                             $time, steps[i].addr);
                    errors++;
                end
                if (wb_count > wb_before) begin
                    checks++;
                    assert (last_wb == steps[i].wb_addr) else begin
                        $display("MISMATCH time=%0t writeback dfp_addr got %h expected %h",
                                 $time, last_wb, steps[i].wb_addr);
                        errors++;
                    end
                end
            end
            if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
                $display("test %0d %s: %0d errors", steps[i].test, names[steps[i].test],
                         errors - err_start);
                err_start = errors;
            end
        end
        ufp_rmask = '0;
        ufp_wmask = '0;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* tests/mem_model.sv */
module mem_model #(
    parameter int          latency  = 4,
    parameter logic [31:0] fill_key = 32'h0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [31:0]        dfp_addr,
    input  logic               dfp_read,
    input  logic               dfp_write,
    input  cache_types::line_t dfp_wdata,
    output cache_types::line_t dfp_rdata,
    output logic               dfp_resp
);

    cache_types::line_t lines [logic [31:0]];
    int                 count;

    // Untouched memory holds each word's byte address mixed with the key.
    function automatic cache_types::line_t initial_line(input logic [31:0] line_addr);
        cache_types::line_t l;
        for (int i = 0; i < 8; i++) begin
            l[i * 32 +: 32] = (line_addr + 32'(i * 4)) ^ fill_key;
        end
        return l;
    endfunction

    initial begin
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            dfp_resp  <= 1'b0;
            dfp_rdata <= '0;
            count     <= 0;
        end else if (dfp_resp) begin
            dfp_resp <= 1'b0;     // The cache drops its request on this edge.
            count    <= 0;
        end else if (dfp_read || dfp_write) begin
            if (count == latency - 1) begin
                dfp_resp <= 1'b1;
                count    <= 0;
                if (dfp_write) begin
                    lines[dfp_addr] = dfp_wdata;
                end else if (lines.exists(dfp_addr)) begin
                    dfp_rdata <= lines[dfp_addr];
                end else begin
                    dfp_rdata <= initial_line(dfp_addr);
                end
            end else begin
                count <= count + 1;
            end
        end
    end

endmodule

/* hdl/cache.sv */
module cache (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [31:0]        ufp_addr,
    input  logic [3:0]         ufp_rmask,
    input  logic [3:0]         ufp_wmask,
    input  logic [31:0]        ufp_wdata,
    output logic [31:0]        ufp_rdata,
    output logic               ufp_resp,
    output logic [31:0]        dfp_addr,
    output logic               dfp_read,
    output logic               dfp_write,
    output cache_types::line_t dfp_wdata,
    input  cache_types::line_t dfp_rdata,
    input  logic               dfp_resp
);

    cache_types::pipe_reg_t              pipe_reg;
    cache_types::pipe_reg_t              pipe_reg_next;
    cache_types::line_t                  cache_data [cache_geom_pkg::NUM_WAYS];
    cache_types::tag_entry_t             tag_out [cache_geom_pkg::NUM_WAYS];
    cache_types::tag_entry_t             tag_din;
    cache_types::line_t                  data_din;
    logic [cache_geom_pkg::NUM_WAYS-1:0] web;
    logic [cache_geom_pkg::NUM_WAYS-1:0] valid_q [cache_geom_pkg::NUM_SETS];
    logic [cache_geom_pkg::WAY_W-1:0]    cache_hit_way;
    logic [cache_geom_pkg::WAY_W-1:0]    cache_replace_way;
    logic [cache_geom_pkg::LRU_W-1:0]    lru;
    logic                                dirty_bit;
    logic                                valid;
    logic                                dirty_miss_next;
    logic                                stall;
    logic                                write_stall;
    logic                                write_flag;
    logic                                lru_update;
    logic                                miss_req;
    logic                                victim_dirty;
    logic                                miss_done;
    logic                                valid_set;

    assign tag_din = '{tag: pipe_reg.tag, dirty: dirty_bit};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pipe_reg.active <= 1'b0;
        end else if (!write_stall) begin
            pipe_reg <= pipe_reg_next;
        end
    end

    // Valid bits change only when a miss fills or gives up the victim way.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < cache_geom_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (valid_set || dirty_miss_next) begin
            valid_q[pipe_reg.index][cache_replace_way] <= valid;
        end
    end

    for (genvar w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin : g_way
        cache_array #(.word_t(cache_types::line_t)) data_array (
            .clk  (clk),
            .csb  (1'b0),
            .web  (web[w]),
            .addr (pipe_reg_next.index),
            .din  (data_din),
            .dout (cache_data[w])
        );
        cache_array #(.word_t(cache_types::tag_entry_t)) tag_array (
            .clk  (clk),
            .csb  (1'b0),
            .web  (web[w]),
            .addr (pipe_reg_next.index),
            .din  (tag_din),
            .dout (tag_out[w])
        );
    end

    pipe_one u_pipe_one (
        .ufp_addr          (ufp_addr),
        .ufp_wdata         (ufp_wdata),
        .ufp_rmask         (ufp_rmask),
        .ufp_wmask         (ufp_wmask),
        .dfp_resp          (dfp_resp),
        .dfp_rdata         (dfp_rdata),
        .lru               (lru),
        .pipe_reg          (pipe_reg),
        .stall             (stall),
        .cache_hit_way     (cache_hit_way),
        .cache_data        (cache_data),
        .write_stall       (write_stall),
        .write_flag        (write_flag),
        .dfp_write         (dfp_write),
        .pipe_reg_next     (pipe_reg_next),
        .web               (web),
        .data_din          (data_din),
        .dirty_bit         (dirty_bit),
        .cache_replace_way (cache_replace_way),
        .valid             (valid),
        .dirty_miss_next   (dirty_miss_next)
    );

    pipe_two u_pipe_two (
        .clk           (clk),
        .rst_n         (rst_n),
        .pipe_reg      (pipe_reg),
        .tag_out       (tag_out),
        .valid_bits    (valid_q[pipe_reg.index]),
        .cache_data    (cache_data),
        .miss_done     (miss_done),
        .ufp_resp      (ufp_resp),
        .ufp_rdata     (ufp_rdata),
        .stall         (stall),
        .write_stall   (write_stall),
        .write_flag    (write_flag),
        .cache_hit_way (cache_hit_way),
        .lru_update    (lru_update),
        .miss_req      (miss_req),
        .victim_dirty  (victim_dirty)
    );

    plru u_plru (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_index   (pipe_reg_next.index),
        .lru_update (lru_update),
        .wr_index   (pipe_reg.index),
        .access_way (cache_hit_way),
        .lru        (lru)
    );

    miss_ctrl u_miss_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .miss_req        (miss_req),
        .victim_dirty    (victim_dirty),
        .victim_tag      (tag_out[cache_replace_way].tag),
        .pipe_reg        (pipe_reg),
        .victim_line     (cache_data[cache_replace_way]),
        .dfp_resp        (dfp_resp),
        .dirty_miss_next (dirty_miss_next),
        .dfp_addr        (dfp_addr),
        .dfp_read        (dfp_read),
        .dfp_write       (dfp_write),
        .dfp_wdata       (dfp_wdata),
        .miss_done       (miss_done),
        .valid_set       (valid_set)
    );

endmodule

/* hdl/miss_ctrl.sv */
module miss_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             miss_req,
    input  logic                             victim_dirty,
    input  logic [cache_geom_pkg::TAG_W-1:0] victim_tag,
    input  cache_types::pipe_reg_t           pipe_reg,
    input  cache_types::line_t               victim_line,
    input  logic                             dfp_resp,
    input  logic                             dirty_miss_next,
    output logic [31:0]                      dfp_addr,
    output logic                             dfp_read,
    output logic                             dfp_write,
    output cache_types::line_t               dfp_wdata,
    output logic                             miss_done,
    output logic                             valid_set
);

    cache_types::miss_state_t state;
    cache_types::miss_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            cache_types::idle: begin
                if (miss_req) begin
                    state_next = victim_dirty ? cache_types::writeback : cache_types::fill;
                end
            end
            cache_types::writeback: begin
                if (dirty_miss_next) begin
                    state_next = cache_types::fill;
                end
            end
            cache_types::fill: begin
                if (dfp_resp) begin
                    state_next = cache_types::idle;
                end
            end
            default: state_next = cache_types::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= cache_types::idle;
            miss_done <= 1'b0;
        end else begin
            state     <= state_next;
            miss_done <= (state == cache_types::fill) && dfp_resp;
        end
    end

    assign dfp_read  = (state == cache_types::fill);
    assign dfp_write = (state == cache_types::writeback);
    assign dfp_wdata = victim_line;      // Array output is steady while the set is held.
    assign valid_set = (state == cache_types::fill) && dfp_resp;

    // Write-back goes to the victim's own line address.
    assign dfp_addr = (state == cache_types::writeback) ?
        {victim_tag, pipe_reg.index, {cache_geom_pkg::OFFSET_W{1'b0}}} :
        {pipe_reg.tag, pipe_reg.index, {cache_geom_pkg::OFFSET_W{1'b0}}};

endmodule

/* hdl/pipe_two.sv */
module pipe_two (
    input  logic                                clk,
    input  logic                                rst_n,
    input  cache_types::pipe_reg_t              pipe_reg,
    input  cache_types::tag_entry_t             tag_out [cache_geom_pkg::NUM_WAYS],
    input  logic [cache_geom_pkg::NUM_WAYS-1:0] valid_bits,
    input  cache_types::line_t                  cache_data [cache_geom_pkg::NUM_WAYS],
    input  logic                                miss_done,
    output logic                                ufp_resp,
    output logic [31:0]                         ufp_rdata,
    output logic                                stall,
    output logic                                write_stall,
    output logic                                write_flag,
    output logic [cache_geom_pkg::WAY_W-1:0]    cache_hit_way,
    output logic                                lru_update,
    output logic                                miss_req,
    output logic                                victim_dirty
);

    logic [cache_geom_pkg::NUM_WAYS-1:0] hit_vec;
    logic [cache_geom_pkg::WAY_W-1:0]    victim;
    logic                                lookup;
    logic                                hit;
    logic                                miss;
    logic                                write_done;

    always_comb begin
        // Array outputs are stale right after a merge or a fill.
        lookup        = pipe_reg.active && !miss_done && !write_done;
        cache_hit_way = '0;
        for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
            hit_vec[w] = valid_bits[w] && (tag_out[w].tag == pipe_reg.tag);
            if (hit_vec[w]) begin
                cache_hit_way = w[cache_geom_pkg::WAY_W-1:0];
            end
        end

        hit  = lookup && (|hit_vec);
        miss = lookup && !(|hit_vec);

        ufp_resp    = hit;
        lru_update  = hit;
        write_flag  = hit && (|pipe_reg.ufp_wmask);
        write_stall = write_flag;     // The merge needs the array port next edge.

        stall    = miss || miss_done;     // Hold one more cycle to re-read the filled line.
        miss_req = miss;

        victim       = cache_types::victim_way(pipe_reg.lru);
        victim_dirty = valid_bits[victim] && tag_out[victim].dirty;

        ufp_rdata = cache_data[cache_hit_way][pipe_reg.offset[cache_geom_pkg::OFFSET_W-1:2] * 32
                                              +: 32];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            write_done <= 1'b0;
        end else begin
            write_done <= write_flag;
        end
    end

endmodule

/* hdl/pipe_one.sv */
module pipe_one (
    input  logic [31:0]                        ufp_addr,
    input  logic [31:0]                        ufp_wdata,
    input  logic [3:0]                         ufp_rmask,
    input  logic [3:0]                         ufp_wmask,
    input  logic                               dfp_resp,
    input  cache_types::line_t                 dfp_rdata,
    input  logic [cache_geom_pkg::LRU_W-1:0]   lru,
    input  cache_types::pipe_reg_t             pipe_reg,
    input  logic                               stall,
    input  logic [cache_geom_pkg::WAY_W-1:0]   cache_hit_way,
    input  cache_types::line_t                 cache_data [cache_geom_pkg::NUM_WAYS],
    input  logic                               write_stall,
    input  logic                               write_flag,
    input  logic                               dfp_write,
    output cache_types::pipe_reg_t             pipe_reg_next,
    output logic [cache_geom_pkg::NUM_WAYS-1:0] web,
    output cache_types::line_t                 data_din,
    output logic                               dirty_bit,
    output logic [cache_geom_pkg::WAY_W-1:0]   cache_replace_way,
    output logic                               valid,
    output logic                               dirty_miss_next
);

    logic [7:0] word_lsb;

    // Request capture. The index of pipe_reg_next also addresses the arrays.
    always_comb begin
        if (stall || write_stall) begin
            pipe_reg_next = pipe_reg;     // Miss or merge in progress holds the set.
        end else begin
            pipe_reg_next.offset    = ufp_addr[cache_geom_pkg::OFFSET_W-1:0];
            pipe_reg_next.index     = ufp_addr[cache_geom_pkg::OFFSET_W +: cache_geom_pkg::INDEX_W];
            pipe_reg_next.tag       = ufp_addr[31 -: cache_geom_pkg::TAG_W];
            pipe_reg_next.ufp_rmask = ufp_rmask;
            pipe_reg_next.ufp_wmask = ufp_wmask;
            pipe_reg_next.ufp_wdata = ufp_wdata;
            pipe_reg_next.lru       = lru;
            pipe_reg_next.active    = (|ufp_rmask) || (|ufp_wmask);
        end
    end

    // The array write merges store data on a write hit or lands a fill on a read response.
    always_comb begin
        word_lsb          = {pipe_reg.offset[cache_geom_pkg::OFFSET_W-1:2], 5'b00000};
        cache_replace_way = cache_types::victim_way(pipe_reg.lru);
        web               = '1;
        valid             = 1'b1;
        data_din          = dfp_rdata;
        dirty_bit         = 1'b0;
        dirty_miss_next   = 1'b0;

        if (write_flag) begin
            data_din = cache_data[cache_hit_way];
            for (int b = 0; b < 4; b++) begin
                if (pipe_reg.ufp_wmask[b]) begin
                    data_din[word_lsb + b * 8 +: 8] = pipe_reg.ufp_wdata[b * 8 +: 8];
                end
            end
            dirty_bit          = 1'b1;
            web[cache_hit_way] = 1'b0;
        end else if (dfp_resp && !dfp_write) begin
            web[cache_replace_way] = 1'b0;     // Fill lands in the victim way.
        end else if (dfp_resp && dfp_write) begin
            valid           = 1'b0;            // Victim is gone once memory holds it.
            dirty_miss_next = 1'b1;
        end
    end

endmodule

/* hdl/plru.sv */
module plru (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [cache_geom_pkg::INDEX_W-1:0] rd_index,
    input  logic                               lru_update,
    input  logic [cache_geom_pkg::INDEX_W-1:0] wr_index,
    input  logic [cache_geom_pkg::WAY_W-1:0]   access_way,
    output logic [cache_geom_pkg::LRU_W-1:0]   lru
);

    logic [cache_geom_pkg::LRU_W-1:0] lru_q [cache_geom_pkg::NUM_SETS];
    logic [cache_geom_pkg::LRU_W-1:0] lru_new;

    // Point the tree away from the way just used.
    always_comb begin
        lru_new = lru_q[wr_index];
        if (!access_way[1]) begin
            lru_new[2] = 1'b1;
            lru_new[1] = !access_way[0];
        end else begin
            lru_new[2] = 1'b0;
            lru_new[0] = !access_way[0];
        end
        // A hit in the same set this cycle is passed straight through.
        lru = (lru_update && (wr_index == rd_index)) ? lru_new : lru_q[rd_index];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < cache_geom_pkg::NUM_SETS; s++) begin
                lru_q[s] <= '0;
            end
        end else if (lru_update) begin
            lru_q[wr_index] <= lru_new;
        end
    end

endmodule

/* hdl/cache_array.sv */
module cache_array #(
    parameter type word_t = logic [31:0]
) (
    input  logic                               clk,
    input  logic                               csb,
    input  logic                               web,
    input  logic [cache_geom_pkg::INDEX_W-1:0] addr,
    input  word_t                              din,
    output word_t                              dout
);

    word_t mem [cache_geom_pkg::NUM_SETS];

    // A cycle on the single port either writes or reads.
    always_ff @(posedge clk) begin
        if (!csb) begin
            if (!web) begin
                mem[addr] <= din;     // Output keeps the last read word.
            end else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

/* hdl/cache_types.sv */
package cache_types;

    typedef logic [cache_geom_pkg::LINE_W-1:0] line_t;

    // Request held between stage one and stage two.
    typedef struct packed {
        logic [cache_geom_pkg::OFFSET_W-1:0] offset;
        logic [cache_geom_pkg::INDEX_W-1:0]  index;
        logic [cache_geom_pkg::TAG_W-1:0]    tag;
        logic [3:0]                          ufp_rmask;
        logic [3:0]                          ufp_wmask;
        logic [31:0]                         ufp_wdata;
        logic [cache_geom_pkg::LRU_W-1:0]    lru;       // Set state seen at capture.
        logic                                active;
    } pipe_reg_t;

    typedef struct packed {
        logic [cache_geom_pkg::TAG_W-1:0] tag;
        logic                             dirty;
    } tag_entry_t;

    typedef enum logic [1:0] {
        idle,
        writeback,
        fill
    } miss_state_t;

    // Bit 2 chooses the pair, then bit 1 or bit 0 chooses the way inside it.
    function automatic logic [cache_geom_pkg::WAY_W-1:0] victim_way(
        input logic [cache_geom_pkg::LRU_W-1:0] lru
    );
        logic [cache_geom_pkg::WAY_W-1:0] way;
        if (lru[2]) begin
            way = {1'b1, lru[0]};
        end else begin
            way = {1'b0, lru[1]};
        end
        return way;
    endfunction

endpackage

/* hdl/cache_geom_pkg.sv */
package cache_geom_pkg;

    // A 32-bit byte address splits into tag, set index and line offset.
    localparam int OFFSET_W = 5;     // Byte offset inside a 32-byte line.
    localparam int INDEX_W  = 4;     // Selects one of the sets.
    localparam int TAG_W    = 23;    // Remaining upper address bits.

    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 16;

    localparam int LINE_W = 256;     // One full line as moved on the downstream port.

    localparam int WAY_W = 2;        // Encoded way number.
    localparam int LRU_W = 3;        // Tree pseudo-LRU bits for one set.

endpackage
